/* hdl/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  // Bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int be_w = 4;

  // Word address taken from bits 11:2
  localparam int ram_words = 1024;
  localparam int word_lsb = 2;
  localparam int word_w = $clog2(ram_words);

  // Lowest address bit of the region select
  localparam int region_lsb = word_lsb + word_w;

  // Address map
  localparam logic [addr_w-1:0] fast_base = 32'h0000_0000;
  localparam logic [addr_w-1:0] slow_base = 32'h0001_0000;

  // Extra wait cycles per region
  localparam int wait_w = 3;
  localparam logic [wait_w-1:0] fast_wait = 3'd0;
  localparam logic [wait_w-1:0] slow_wait = 3'd4;

  // Chip select vector layout
  localparam int num_cs = 2;
  localparam int cs_fast = 0;
  localparam int cs_slow = 1;

  // Current bus owner
  typedef enum logic {
    cpu,
    disp
  } master_t;

endpackage

`default_nettype wire

/* hdl/slave_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface slave_if;

  logic                            read;
  logic                            write;
  // Word index inside the slave
  logic [soc_bus_pkg::word_w-1:0]  address;
  logic [soc_bus_pkg::data_w-1:0]  writedata;
  logic [soc_bus_pkg::be_w-1:0]    byteenable;
  logic [soc_bus_pkg::data_w-1:0]  readdata;

  modport ctrl (
    output read,
    output write,
    output address,
    output writedata,
    output byteenable,
    input  readdata
  );

  modport mem (
    input  read,
    input  write,
    input  address,
    input  writedata,
    input  byteenable,
    output readdata
  );

endinterface

`default_nettype wire

/* hdl/bus_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_controller (
  input  wire                  clock,
  input  wire                  arst_n,
  input  wire                  cpu_req,
  input  wire                  cpu_enable,
  input  wire                  disp_req,
  input  wire                  disp_enable,
  input  wire                  done,
  output soc_bus_pkg::master_t owner,
  output logic                 start,
  output logic                 active,
  output logic                 cpu_wait,
  output logic                 disp_wait
);

  typedef enum logic [1:0] {
    st_idle,
    st_grant,
    st_finish
  } state_t;

  state_t               state;
  state_t               state_nxt;
  soc_bus_pkg::master_t owner_q;
  soc_bus_pkg::master_t pick;
  logic                 cpu_ok;
  logic                 disp_ok;
  logic                 cpu_finish;
  logic                 disp_finish;

  // Disabled masters are invisible to arbitration
  assign cpu_ok = cpu_req & cpu_enable;
  assign disp_ok = disp_req & disp_enable;

  // Display wins a tie
  assign pick = disp_ok ? soc_bus_pkg::disp : soc_bus_pkg::cpu;

  // Owner follows the pick while idle so the decoder can strobe in the start cycle
  assign owner = (state == st_idle) ? pick : owner_q;
  assign start = (state == st_idle) & (cpu_ok | disp_ok);
  assign active = (state != st_idle);

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start) begin
          state_nxt = st_grant;
        end
      end
      st_grant: begin
        if (done) begin
          state_nxt = st_finish;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      owner_q <= soc_bus_pkg::cpu;
    end else begin
      state <= state_nxt;
      if (start) begin
        owner_q <= pick;
      end
    end
  end

  assign cpu_finish = (state == st_finish) & (owner_q == soc_bus_pkg::cpu);
  assign disp_finish = (state == st_finish) & (owner_q == soc_bus_pkg::disp);

  // Wait drops only in the owner's finish cycle
  assign cpu_wait = cpu_req & ~cpu_finish;
  assign disp_wait = disp_req & ~disp_finish;

endmodule

`default_nettype wire

/* hdl/wait_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module wait_timer (
  input  wire                             clock,
  input  wire                             arst_n,
  input  wire                             load,
  input  wire [soc_bus_pkg::wait_w-1:0]   count,
  output logic                            done
);

  logic [soc_bus_pkg::wait_w-1:0] remaining;
  logic                           armed;

  // Fires once per load and count+1 cycles after it
  assign done = armed & (remaining == '0);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      remaining <= '0;
      armed <= 1'b0;
    end else if (load) begin
      remaining <= count;
      armed <= 1'b1;
    end else if (done) begin
      armed <= 1'b0;
    end else if (armed) begin
      remaining <= remaining - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/address_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module address_decoder (
  input  var soc_bus_pkg::master_t        owner,
  input  wire                             active,
  input  wire                             start,
  input  wire [soc_bus_pkg::addr_w-1:0]   cpu_address,
  input  wire                             cpu_write,
  input  wire [soc_bus_pkg::data_w-1:0]   cpu_writedata,
  input  wire [soc_bus_pkg::be_w-1:0]     cpu_be,
  input  wire [soc_bus_pkg::addr_w-1:0]   disp_address,
  output logic [soc_bus_pkg::wait_w-1:0]  wait_count,
  slave_if.ctrl                           fast,
  slave_if.ctrl                           slow,
  output logic [soc_bus_pkg::data_w-1:0]  readdata
);

  logic [soc_bus_pkg::addr_w-1:0] address;
  logic [soc_bus_pkg::data_w-1:0] writedata;
  logic [soc_bus_pkg::be_w-1:0]   byteenable;
  logic                           write;
  logic                           read;
  logic [soc_bus_pkg::num_cs-1:0] hit;
  logic [soc_bus_pkg::num_cs-1:0] cs;

  // Display port only reads whole words
  always_comb begin
    if (owner == soc_bus_pkg::disp) begin
      address = disp_address;
      writedata = '0;
      byteenable = '1;
      write = 1'b0;
    end else begin
      address = cpu_address;
      writedata = cpu_writedata;
      byteenable = cpu_be;
      write = cpu_write;
    end
  end

  // Any request that is not a write is a read
  assign read = ~write;

  assign hit[soc_bus_pkg::cs_fast] = (address[soc_bus_pkg::addr_w-1:soc_bus_pkg::region_lsb] ==
    soc_bus_pkg::fast_base[soc_bus_pkg::addr_w-1:soc_bus_pkg::region_lsb]);
  assign hit[soc_bus_pkg::cs_slow] = (address[soc_bus_pkg::addr_w-1:soc_bus_pkg::region_lsb] ==
    soc_bus_pkg::slow_base[soc_bus_pkg::addr_w-1:soc_bus_pkg::region_lsb]);

  // No chip select outside a transfer
  assign cs = hit & {soc_bus_pkg::num_cs{start | active}};

  always_comb begin
    if (hit[soc_bus_pkg::cs_slow]) begin
      wait_count = soc_bus_pkg::slow_wait;
    end else if (hit[soc_bus_pkg::cs_fast]) begin
      wait_count = soc_bus_pkg::fast_wait;
    end else begin
      wait_count = '0;
    end
  end

  // Strobes only in the start cycle, so each access hits the slave once
  assign fast.read = cs[soc_bus_pkg::cs_fast] & start & read;
  assign fast.write = cs[soc_bus_pkg::cs_fast] & start & write;
  assign fast.address = address[soc_bus_pkg::region_lsb-1:soc_bus_pkg::word_lsb];
  assign fast.writedata = writedata;
  assign fast.byteenable = byteenable;

  assign slow.read = cs[soc_bus_pkg::cs_slow] & start & read;
  assign slow.write = cs[soc_bus_pkg::cs_slow] & start & write;
  assign slow.address = address[soc_bus_pkg::region_lsb-1:soc_bus_pkg::word_lsb];
  assign slow.writedata = writedata;
  assign slow.byteenable = byteenable;

  // Unmapped reads come back as zero
  assign readdata = ({soc_bus_pkg::data_w{cs[soc_bus_pkg::cs_fast]}} & fast.readdata) |
                    ({soc_bus_pkg::data_w{cs[soc_bus_pkg::cs_slow]}} & slow.readdata);

endmodule

`default_nettype wire

/* hdl/scratch_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
  input  wire   clock,
  slave_if.mem  port
);

  logic [soc_bus_pkg::data_w-1:0] mem [soc_bus_pkg::ram_words];

  // Byte lane writes
  always_ff @(posedge clock) begin
    if (port.write) begin
      for (int b = 0; b < soc_bus_pkg::be_w; b++) begin
        if (port.byteenable[b]) begin
          mem[port.address][8*b +: 8] <= port.writedata[8*b +: 8];
        end
      end
    end
  end

  // Registered read held until the next read strobe
  always_ff @(posedge clock) begin
    if (port.read) begin
      port.readdata <= mem[port.address];
    end
  end

endmodule

`default_nettype wire

/* hdl/soc_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus (
  input  wire                             clock,
  input  wire                             arst_n,
  input  wire                             cpu_enable,
  input  wire                             disp_enable,
  // CPU master
  input  wire [soc_bus_pkg::addr_w-1:0]   cpu_address,
  input  wire                             cpu_read,
  input  wire                             cpu_write,
  input  wire [soc_bus_pkg::data_w-1:0]   cpu_writedata,
  input  wire [soc_bus_pkg::be_w-1:0]     cpu_be,
  output wire [soc_bus_pkg::data_w-1:0]   cpu_readdata,
  output wire                             cpu_wait,
  // Display fetch master
  input  wire [soc_bus_pkg::addr_w-1:0]   disp_address,
  input  wire                             disp_read,
  output wire [soc_bus_pkg::data_w-1:0]   disp_readdata,
  output wire                             disp_wait
);

  soc_bus_pkg::master_t           owner;
  wire                            start;
  wire                            active;
  wire                            done;
  wire                            cpu_req;
  wire [soc_bus_pkg::wait_w-1:0]  wait_count;
  wire [soc_bus_pkg::data_w-1:0]  bus_readdata;

  slave_if fast_bus ();
  slave_if slow_bus ();

  assign cpu_req = cpu_read | cpu_write;

  // Both masters see the merged read data
  assign cpu_readdata = bus_readdata;
  assign disp_readdata = bus_readdata;

  bus_controller i_bus_controller (
    .clock       (clock),
    .arst_n      (arst_n),
    .cpu_req     (cpu_req),
    .cpu_enable  (cpu_enable),
    .disp_req    (disp_read),
    .disp_enable (disp_enable),
    .done        (done),
    .owner       (owner),
    .start       (start),
    .active      (active),
    .cpu_wait    (cpu_wait),
    .disp_wait   (disp_wait)
  );

  wait_timer i_wait_timer (
    .clock  (clock),
    .arst_n (arst_n),
    .load   (start),
    .count  (wait_count),
    .done   (done)
  );

  address_decoder i_address_decoder (
    .owner         (owner),
    .active        (active),
    .start         (start),
    .cpu_address   (cpu_address),
    .cpu_write     (cpu_write),
    .cpu_writedata (cpu_writedata),
    .cpu_be        (cpu_be),
    .disp_address  (disp_address),
    .wait_count    (wait_count),
    .fast          (fast_bus.ctrl),
    .slow          (slow_bus.ctrl),
    .readdata      (bus_readdata)
  );

  // On-chip scratch with no extra waits
  scratch_ram fast_ram (
    .clock (clock),
    .port  (fast_bus.mem)
  );

  // Stand-in for external SSRAM
  scratch_ram slow_ram (
    .clock (clock),
    .port  (slow_bus.mem)
  );

endmodule

`default_nettype wire

/* testbench/tb_soc_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

  logic        clock = 1'b0;
  logic        arst_n;
  logic        cpu_enable;
  logic        disp_enable;
  logic [31:0] cpu_address;
  logic        cpu_read;
  logic        cpu_write;
  logic [31:0] cpu_writedata;
  logic [3:0]  cpu_be;
  logic [31:0] cpu_readdata;
  logic        cpu_wait;
  logic [31:0] disp_address;
  logic        disp_read;
  logic [31:0] disp_readdata;
  logic        disp_wait;

  // One table entry per transaction line
  int          t_mst [64];
  int          t_op [64];
  logic [31:0] t_addr [64];
  logic [3:0]  t_be [64];
  logic [31:0] t_wdata [64];
  logic [31:0] t_exp [64];
  int          t_chk [64];
  int          t_lat [64];
  int          n_lines = 0;
  logic        loaded = 1'b0;
  integer      seed = 34;

  // Reference contents of both RAMs
  logic [31:0] fast_model [1024];
  logic [31:0] slow_model [1024];

  always #5 clock = ~clock;

  soc_bus i_soc_bus (
    .clock         (clock),
    .arst_n        (arst_n),
    .cpu_enable    (cpu_enable),
    .disp_enable   (disp_enable),
    .cpu_address   (cpu_address),
    .cpu_read      (cpu_read),
    .cpu_write     (cpu_write),
    .cpu_writedata (cpu_writedata),
    .cpu_be        (cpu_be),
    .cpu_readdata  (cpu_readdata),
    .cpu_wait      (cpu_wait),
    .disp_address  (disp_address),
    .disp_read     (disp_read),
    .disp_readdata (disp_readdata),
    .disp_wait     (disp_wait)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else begin
      $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, expected);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // 0 fast, 1 slow, 2 unmapped
  function automatic int region_of(input logic [31:0] addr);
    if (addr[31:12] == soc_bus_pkg::fast_base[31:12]) begin
      return 0;
    end else if (addr[31:12] == soc_bus_pkg::slow_base[31:12]) begin
      return 1;
    end else begin
      return 2;
    end
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    case (region_of(addr))
      0: return fast_model[addr[11:2]];
      1: return slow_model[addr[11:2]];
      default: return 32'h0;
    endcase
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
    logic [31:0] word;
    int          region;
    region = region_of(addr);
    word = model_read(addr);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    if (region == 0) begin
      fast_model[addr[11:2]] = word;
    end else if (region == 1) begin
      slow_model[addr[11:2]] = word;
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          got;
    string       line;
    int          f_mst;
    int          f_op;
    int          f_chk;
    int          f_lat;
    logic [31:0] f_addr;
    logic [3:0]  f_be;
    logic [31:0] f_wdata;
    logic [31:0] f_exp;
    fd = $fopen("testbench/bus_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file testbench/bus_stimulus.txt");
      $display("SIMULATION FAILED");
      $fatal(1);
    end else begin
      while ($fgets(line, fd) != 0 && n_lines < 64) begin
        // Skip comments and blank lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          got = $sscanf(line, "%d %d %h %h %h %h %d %d", f_mst, f_op, f_addr, f_be,
                        f_wdata, f_exp, f_chk, f_lat);
          if (got != 8) begin
            $display("Malformed stimulus line: %s", line);
            $display("SIMULATION FAILED");
            $fatal(1);
          end else begin
            t_mst[n_lines] = f_mst;
            t_op[n_lines] = f_op;
            t_addr[n_lines] = f_addr;
            t_be[n_lines] = f_be;
            t_wdata[n_lines] = f_wdata;
            t_exp[n_lines] = f_exp;
            t_chk[n_lines] = f_chk;
            t_lat[n_lines] = f_lat;
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One master alone
  // Line type 3 holds cpu_enable low for lat cycles first
  task automatic run_single(input int i);
    logic        is_disp;
    int          cycles;
    logic [31:0] rdata;
    string       port_name;
    is_disp = (t_mst[i] == 1);
    port_name = is_disp ? "disp_readdata" : "cpu_readdata";
    if (t_mst[i] == 3) begin
      cpu_enable = 1'b0;
    end
    if (is_disp) begin
      disp_address = t_addr[i];
      disp_read = 1'b1;
    end else begin
      cpu_address = t_addr[i];
      cpu_be = t_be[i];
      cpu_writedata = t_wdata[i];
      cpu_read = (t_op[i] == 0);
      cpu_write = (t_op[i] == 1);
    end
    if (t_mst[i] == 3) begin
      repeat (t_lat[i]) begin
        @(negedge clock);
        check_value("cpu_wait", {31'b0, cpu_wait}, 32'd1);
      end
      cpu_enable = 1'b1;
    end
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (is_disp ? disp_wait : cpu_wait);
    rdata = is_disp ? disp_readdata : cpu_readdata;
    disp_read = 1'b0;
    cpu_read = 1'b0;
    cpu_write = 1'b0;
    if (t_op[i] == 0) begin
      if (t_chk[i] != 0) begin
        check_value(port_name, rdata, t_exp[i]);
      end
      check_value(port_name, rdata, model_read(t_addr[i]));
    end else begin
      model_write(t_addr[i], t_be[i], t_wdata[i]);
    end
    if (t_mst[i] != 3 && t_lat[i] != 0) begin
      check_value("wait cycles", cycles, t_lat[i]);
    end
  endtask

  // Both masters request in the same idle cycle
  task automatic run_both(input int i);
    logic [31:0] c_addr;
    logic [31:0] d_addr;
    logic        disp_pending;
    logic        cpu_pending;
    c_addr = t_addr[i] + (($random(seed) & 32'h3) << 2);
    d_addr = t_addr[i] + (($random(seed) & 32'h3) << 2);
    disp_address = d_addr;
    disp_read = 1'b1;
    cpu_address = c_addr;
    cpu_be = t_be[i];
    cpu_writedata = t_wdata[i];
    cpu_read = (t_op[i] == 0);
    cpu_write = (t_op[i] == 1);
    disp_pending = 1'b1;
    cpu_pending = 1'b1;
    while (disp_pending || cpu_pending) begin
      @(negedge clock);
      if (disp_pending && !disp_wait) begin
        check_value("disp_readdata", disp_readdata, model_read(d_addr));
        disp_read = 1'b0;
        disp_pending = 1'b0;
      end else if (cpu_pending && !cpu_wait) begin
        assert (!disp_pending) else begin
          $display("Arbitration error: the CPU transfer finished before the display read");
          $display("SIMULATION FAILED");
          $fatal(1);
        end
        if (t_op[i] == 0) begin
          check_value("cpu_readdata", cpu_readdata, model_read(c_addr));
        end else begin
          model_write(c_addr, t_be[i], t_wdata[i]);
        end
        cpu_read = 1'b0;
        cpu_write = 1'b0;
        cpu_pending = 1'b0;
      end
    end
    // Read back the word the CPU wrote
    if (t_op[i] == 1) begin
      @(negedge clock);
      cpu_read = 1'b1;
      do begin
        @(negedge clock);
      end while (cpu_wait);
      check_value("cpu_readdata", cpu_readdata, model_read(c_addr));
      cpu_read = 1'b0;
    end
  endtask

  initial begin
    arst_n = 1'b0;
    cpu_enable = 1'b1;
    disp_enable = 1'b1;
    cpu_address = '0;
    cpu_read = 1'b0;
    cpu_write = 1'b0;
    cpu_writedata = '0;
    cpu_be = '0;
    disp_address = '0;
    disp_read = 1'b0;
    load_stimulus();
    loaded = 1'b1;
    repeat (3) @(negedge clock);
    arst_n = 1'b1;
    @(negedge clock);
    check_value("cpu_wait", {31'b0, cpu_wait}, 32'd0);
    check_value("disp_wait", {31'b0, disp_wait}, 32'd0);
    for (int i = 0; i < n_lines; i++) begin
      @(negedge clock);
      if (t_mst[i] == 2) begin
        run_both(i);
      end else begin
        run_single(i);
      end
    end
    repeat (2) @(negedge clock);
    $display("SIMULATION PASSED");
    $finish;
  end

  // Watchdog sized from the number of stimulus lines
  initial begin
    int limit;
    wait (loaded);
    limit = 40 * n_lines + 10;
    repeat (limit) @(posedge clock);
    $display("Timeout: the transactions did not finish within %0d cycles", limit);
    $display("SIMULATION FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* testbench/bus_stimulus.txt */
# mst: 0 cpu, 1 display, 2 both masters at random word offsets from addr, 3 cpu with enable low
# op (0 read, 1 write), addr, be, wdata, expected (hex), chk (1 compares expected), lat (cycles)
0 1 00000000 f 11111111 00000000 0 2
0 1 00000004 f 22222222 00000000 0 2
0 1 00000008 f 33333333 00000000 0 2
0 1 0000000c f 44444444 00000000 0 2
0 1 00010000 f aaaaaaa0 00000000 0 6
0 1 00010004 f aaaaaaa1 00000000 0 6
0 1 00010008 f aaaaaaa2 00000000 0 6
0 1 0001000c f aaaaaaa3 00000000 0 6
0 0 00000000 f 00000000 11111111 1 2
0 0 00010000 f 00000000 aaaaaaa0 1 6
1 0 00000004 f 00000000 22222222 1 2
1 0 00010004 f 00000000 aaaaaaa1 1 6
0 1 00000008 5 00ee00dd 00000000 0 2
0 0 00000008 f 00000000 33ee33dd 1 2
0 1 0001000c a 12345678 00000000 0 6
0 0 0001000c f 00000000 12aa56a3 1 6
0 1 00020004 f deadbeef 00000000 0 2
0 0 00020004 f 00000000 00000000 1 2
1 0 000ff000 f 00000000 00000000 1 2
0 0 00000004 f 00000000 22222222 1 2
0 0 00010004 f 00000000 aaaaaaa1 1 6
3 0 00000000 f 00000000 11111111 1 8
3 1 00010008 3 0000bbcc 00000000 0 5
0 0 00010008 f 00000000 aaaabbcc 1 6
2 0 00000000 f 00000000 00000000 0 0
2 1 00010000 f 5a5a5a5a 00000000 0 0
2 0 00010000 f 00000000 00000000 0 0

/* sources.f */
hdl/soc_bus_pkg.sv
hdl/slave_if.sv
hdl/bus_controller.sv
hdl/wait_timer.sv
hdl/address_decoder.sv
hdl/scratch_ram.sv
hdl/soc_bus.sv
testbench/tb_soc_bus.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_soc_bus
RTL_TOP   := soc_bus
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
